/* design/cska_pkg.sv */
package cska_pkg;

   // datapath widths fixed by the carry-skip structure.
   localparam int data_w   = 64;
   localparam int group_w  = 16;
   localparam int nibble_w = 4;

   // apb bus widths.
   localparam int apb_addr_w = 8;
   localparam int apb_data_w = 32;

   typedef logic [data_w-1:0]     word_t;
   typedef logic [group_w-1:0]    group_t;
   typedef logic [nibble_w-1:0]   nibble_t;
   typedef logic [apb_addr_w-1:0] apb_addr_t;
   typedef logic [apb_data_w-1:0] apb_data_t;

   // register map.
   localparam apb_addr_t reg_a_lo   = 8'h00;
   localparam apb_addr_t reg_a_hi   = 8'h04;
   localparam apb_addr_t reg_b_lo   = 8'h08;
   localparam apb_addr_t reg_b_hi   = 8'h0C;
   localparam apb_addr_t reg_ctrl   = 8'h10;
   localparam apb_addr_t reg_status = 8'h14;
   localparam apb_addr_t reg_sum_lo = 8'h18;
   localparam apb_addr_t reg_sum_hi = 8'h1C;

   // control and status bit positions.
   localparam int ctrl_cin_bit     = 0;
   localparam int ctrl_start_bit   = 1;
   localparam int status_done_bit  = 0;
   localparam int status_cout_bit  = 1;
   localparam int status_busy_bit  = 2;

   typedef struct packed {
      word_t a;
      word_t b;
      logic  cin;
   } add_op_t;

   typedef struct packed {
      word_t sum;
      logic  cout;
   } add_res_t;

endpackage

/* design/cska_skip_block.sv */
`timescale 1ns/1ps

module cska_skip_block (
   input  cska_pkg::nibble_t a,
   input  cska_pkg::nibble_t b,
   input  logic              cin,
   output cska_pkg::nibble_t sum,
   output logic              cout
);

   cska_pkg::nibble_t             p;
   cska_pkg::nibble_t             g;
   logic [cska_pkg::nibble_w:0]   c;
   logic                          group_p;
   logic                          ripple_cout;

   // per-bit propagate and generate.
   assign p = a ^ b;
   assign g = a & b;

   assign c[0] = cin;

   // ripple chain through the nibble.
   for (genvar i = 0; i < cska_pkg::nibble_w; i++) begin : g_ripple
      assign c[i+1] = g[i] | (p[i] & c[i]);
   end

   assign sum = p ^ c[cska_pkg::nibble_w-1:0];

   assign ripple_cout = c[cska_pkg::nibble_w];

   // all bits propagate, so the carry-in passes straight through.
   assign group_p = &p;

   assign cout = group_p ? cin : ripple_cout;

endmodule

/* design/cska_group16.sv */
`timescale 1ns/1ps

module cska_group16 (
   input  cska_pkg::group_t a,
   input  cska_pkg::group_t b,
   input  logic             cin,
   output cska_pkg::group_t sum,
   output logic             cout
);

   localparam int n_blocks = cska_pkg::group_w / cska_pkg::nibble_w;

   logic [n_blocks:0] carry;

   assign carry[0] = cin;

   // skip blocks chained through their carries.
   for (genvar i = 0; i < n_blocks; i++) begin : g_block
      cska_skip_block u_blk (
         .a    (a[i*cska_pkg::nibble_w +: cska_pkg::nibble_w]),
         .b    (b[i*cska_pkg::nibble_w +: cska_pkg::nibble_w]),
         .cin  (carry[i]),
         .sum  (sum[i*cska_pkg::nibble_w +: cska_pkg::nibble_w]),
         .cout (carry[i+1])
      );
   end

   assign cout = carry[n_blocks];

endmodule

/* design/cska_adder64.sv */
`timescale 1ns/1ps

module cska_adder64 (
   input  logic               clk,
   input  logic               rst,
   input  logic               op_valid,
   input  cska_pkg::add_op_t  op,
   output logic               res_valid,
   output cska_pkg::add_res_t res
);

   localparam int n_groups = cska_pkg::data_w / cska_pkg::group_w;

   cska_pkg::add_op_t    op_r;
   logic                 op_r_valid;
   cska_pkg::word_t      sum_c;
   logic [n_groups:0]    carry;

   // operand stage.
   always_ff @(posedge clk) begin
      if (rst) begin
         op_r_valid <= 1'b0;
      end else begin
         op_r_valid <= op_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (op_valid) begin
         op_r <= op;
      end
   end

   assign carry[0] = op_r.cin;

   for (genvar i = 0; i < n_groups; i++) begin : g_group
      cska_group16 u_grp (
         .a    (op_r.a[i*cska_pkg::group_w +: cska_pkg::group_w]),
         .b    (op_r.b[i*cska_pkg::group_w +: cska_pkg::group_w]),
         .cin  (carry[i]),
         .sum  (sum_c[i*cska_pkg::group_w +: cska_pkg::group_w]),
         .cout (carry[i+1])
      );
   end

   // result stage.
   always_ff @(posedge clk) begin
      if (rst) begin
         res_valid <= 1'b0;
      end else begin
         res_valid <= op_r_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (op_r_valid) begin
         res.sum  <= sum_c;
         res.cout <= carry[n_groups];
      end
   end

endmodule

/* design/cska_apb_regs.sv */
`timescale 1ns/1ps

module cska_apb_regs (
   input  logic                clk,
   input  logic                rst,
   input  cska_pkg::apb_addr_t paddr,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  cska_pkg::apb_data_t pwdata,
   output cska_pkg::apb_data_t prdata,
   output logic                pready,
   output logic                pslverr,
   output logic                op_valid,
   output cska_pkg::add_op_t   op,
   input  logic                res_valid,
   input  cska_pkg::add_res_t  res
);

   localparam int lo_w = cska_pkg::apb_data_w;

   cska_pkg::word_t a_r;
   cska_pkg::word_t b_r;
   logic            cin_r;
   cska_pkg::word_t sum_r;
   logic            cout_r;
   logic            done_r;
   logic            busy_r;

   logic            access;
   logic            mapped;
   logic            read_only;
   logic            wr_en;
   logic            wr_ctrl;
   logic            start;

   assign access = psel & penable;

   always_comb begin
      case (paddr)
         cska_pkg::reg_a_lo,
         cska_pkg::reg_a_hi,
         cska_pkg::reg_b_lo,
         cska_pkg::reg_b_hi,
         cska_pkg::reg_ctrl,
         cska_pkg::reg_status,
         cska_pkg::reg_sum_lo,
         cska_pkg::reg_sum_hi: mapped = 1'b1;
         default:              mapped = 1'b0;
      endcase
   end

   assign read_only = (paddr == cska_pkg::reg_status) |
                      (paddr == cska_pkg::reg_sum_lo) |
                      (paddr == cska_pkg::reg_sum_hi);

   // no wait states.
   assign pready  = 1'b1;
   assign pslverr = access & (~mapped | (pwrite & read_only));

   assign wr_en   = access & pwrite & ~pslverr;
   assign wr_ctrl = wr_en & (paddr == cska_pkg::reg_ctrl);
   assign start   = wr_ctrl & pwdata[cska_pkg::ctrl_start_bit];

   // cin written with the start goes straight into the launched op.
   assign op_valid = start;
   assign op.a     = a_r;
   assign op.b     = b_r;
   assign op.cin   = wr_ctrl ? pwdata[cska_pkg::ctrl_cin_bit] : cin_r;

   always_ff @(posedge clk) begin
      if (rst) begin
         a_r   <= '0;
         b_r   <= '0;
         cin_r <= 1'b0;
      end else if (wr_en) begin
         case (paddr)
            cska_pkg::reg_a_lo: a_r[lo_w-1:0]              <= pwdata;
            cska_pkg::reg_a_hi: a_r[cska_pkg::data_w-1:lo_w] <= pwdata;
            cska_pkg::reg_b_lo: b_r[lo_w-1:0]              <= pwdata;
            cska_pkg::reg_b_hi: b_r[cska_pkg::data_w-1:lo_w] <= pwdata;
            cska_pkg::reg_ctrl: cin_r <= pwdata[cska_pkg::ctrl_cin_bit];
            default: ;
         endcase
      end
   end

   // the later result simply overwrites an earlier one.
   always_ff @(posedge clk) begin
      if (rst) begin
         sum_r  <= '0;
         cout_r <= 1'b0;
      end else if (res_valid) begin
         sum_r  <= res.sum;
         cout_r <= res.cout;
      end
   end

   // a start in the same cycle as a result wins, since a newer op is in flight.
   always_ff @(posedge clk) begin
      if (rst) begin
         done_r <= 1'b0;
         busy_r <= 1'b0;
      end else if (start) begin
         done_r <= 1'b0;
         busy_r <= 1'b1;
      end else if (res_valid) begin
         done_r <= 1'b1;
         busy_r <= 1'b0;
      end
   end

   always_comb begin
      prdata = '0;
      if (access & ~pwrite) begin
         case (paddr)
            cska_pkg::reg_a_lo:   prdata = a_r[lo_w-1:0];
            cska_pkg::reg_a_hi:   prdata = a_r[cska_pkg::data_w-1:lo_w];
            cska_pkg::reg_b_lo:   prdata = b_r[lo_w-1:0];
            cska_pkg::reg_b_hi:   prdata = b_r[cska_pkg::data_w-1:lo_w];
            cska_pkg::reg_ctrl:   prdata[cska_pkg::ctrl_cin_bit] = cin_r;
            cska_pkg::reg_status: begin
               prdata[cska_pkg::status_done_bit] = done_r;
               prdata[cska_pkg::status_cout_bit] = cout_r;
               prdata[cska_pkg::status_busy_bit] = busy_r;
            end
            cska_pkg::reg_sum_lo: prdata = sum_r[lo_w-1:0];
            cska_pkg::reg_sum_hi: prdata = sum_r[cska_pkg::data_w-1:lo_w];
            default:              prdata = '0;
         endcase
      end
   end

endmodule

/* design/cska_apb_top.sv */
`timescale 1ns/1ps

module cska_apb_top (
   input  logic                clk,
   input  logic                rst,
   input  cska_pkg::apb_addr_t paddr,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  cska_pkg::apb_data_t pwdata,
   output cska_pkg::apb_data_t prdata,
   output logic                pready,
   output logic                pslverr
);

   logic               op_valid;
   cska_pkg::add_op_t  op;
   logic               res_valid;
   cska_pkg::add_res_t res;

   cska_apb_regs u_regs (
      .clk       (clk),
      .rst       (rst),
      .paddr     (paddr),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .op_valid  (op_valid),
      .op        (op),
      .res_valid (res_valid),
      .res       (res)
   );

   // two-stage pipelined adder with the result valid two cycles after launch.
   cska_adder64 u_adder (
      .clk       (clk),
      .rst       (rst),
      .op_valid  (op_valid),
      .op        (op),
      .res_valid (res_valid),
      .res       (res)
   );

endmodule

/* sim/cska_apb_chk.sv */
`timescale 1ns/1ps

module cska_apb_chk (
   input logic clk,
   input logic rst,
   input logic op_valid,
   input logic res_valid,
   input logic psel,
   input logic penable,
   input logic pslverr
);

   int fail_count = 0;

   // the adder pipeline is two stages deep and never stalls.
   assert property (@(posedge clk) disable iff (rst) op_valid |-> ##2 res_valid)
      else begin
         $error("res_valid did not follow op_valid after two cycles");
         fail_count++;
      end

   assert property (@(posedge clk) disable iff (rst) res_valid |-> $past(op_valid, 2))
      else begin
         $error("res_valid without an op_valid two cycles earlier");
         fail_count++;
      end

   assert property (@(posedge clk) disable iff (rst) pslverr |-> (psel && penable))
      else begin
         $error("pslverr raised outside an access phase");
         fail_count++;
      end

   assert property (@(posedge clk) rst |-> !op_valid)
      else begin
         $error("op_valid high during reset");
         fail_count++;
      end

endmodule

// the adder has no bus of its own, so its bus inputs see an idle bus.
bind cska_adder64 cska_apb_chk u_chk (
   .clk       (clk),
   .rst       (rst),
   .op_valid  (op_valid),
   .res_valid (res_valid),
   .psel      (1'b0),
   .penable   (1'b0),
   .pslverr   (1'b0)
);

bind cska_apb_regs cska_apb_chk u_chk (
   .clk       (clk),
   .rst       (rst),
   .op_valid  (op_valid),
   .res_valid (res_valid),
   .psel      (psel),
   .penable   (penable),
   .pslverr   (pslverr)
);

/* sim/cska_apb_monitor.sv */
`timescale 1ns/1ps

module cska_apb_monitor (
   input  logic                clk,
   input  logic                rst,
   input  cska_pkg::apb_addr_t paddr,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  cska_pkg::apb_data_t pwdata,
   input  cska_pkg::apb_data_t prdata,
   input  logic                pready,
   input  logic                pslverr,
   output int                  error_count,
   output int                  read_count
);

   cska_pkg::add_op_t  op_m;
   cska_pkg::add_res_t stage_res [2];
   logic [1:0]         stage_v;
   cska_pkg::add_res_t res_m;
   logic               done_m;
   logic               busy_m;

   // 65-bit reference sum with the carry-out in the top bit.
   function automatic cska_pkg::add_res_t ref_add(cska_pkg::word_t a, cska_pkg::word_t b,
                                                  logic cin);
      logic [cska_pkg::data_w:0] full;
      full = a + b + cin;
      return '{sum: full[cska_pkg::data_w-1:0], cout: full[cska_pkg::data_w]};
   endfunction

   // word aligned offsets from 0x00 up to the high sum word.
   function automatic logic is_mapped(cska_pkg::apb_addr_t addr);
      return (addr[1:0] == 2'b00) && (addr <= cska_pkg::reg_sum_hi);
   endfunction

   function automatic logic is_read_only(cska_pkg::apb_addr_t addr);
      return addr inside {cska_pkg::reg_status, cska_pkg::reg_sum_lo, cska_pkg::reg_sum_hi};
   endfunction

   function automatic cska_pkg::apb_data_t expected_read(cska_pkg::apb_addr_t addr);
      cska_pkg::apb_data_t d;
      d = '0;
      case (addr)
         cska_pkg::reg_a_lo:   d = op_m.a[31:0];
         cska_pkg::reg_a_hi:   d = op_m.a[63:32];
         cska_pkg::reg_b_lo:   d = op_m.b[31:0];
         cska_pkg::reg_b_hi:   d = op_m.b[63:32];
         cska_pkg::reg_ctrl:   d[cska_pkg::ctrl_cin_bit] = op_m.cin;
         cska_pkg::reg_status: begin
            d[cska_pkg::status_done_bit] = done_m;
            d[cska_pkg::status_cout_bit] = res_m.cout;
            d[cska_pkg::status_busy_bit] = busy_m;
         end
         cska_pkg::reg_sum_lo: d = res_m.sum[31:0];
         cska_pkg::reg_sum_hi: d = res_m.sum[63:32];
         default:              d = '0;
      endcase
      return d;
   endfunction

   initial begin
      error_count = 0;
      read_count  = 0;
   end

   always @(posedge clk) begin : watch
      logic                access;
      logic                bad;
      logic                start;
      cska_pkg::apb_data_t exp_data;
      if (rst) begin
         op_m      = '0;
         stage_res = '{default: '0};
         stage_v   = '0;
         res_m     = '0;
         done_m    = 1'b0;
         busy_m    = 1'b0;
      end else begin
         access = psel & penable;
         bad    = access & (~is_mapped(paddr) | (pwrite & is_read_only(paddr)));
         start  = access & pwrite & ~bad & (paddr == cska_pkg::reg_ctrl) &
                  pwdata[cska_pkg::ctrl_start_bit];
         if (access) begin
            if (pready !== 1'b1) begin
               error_count++;
               $display("Error: time %0t: pready low in access phase", $time);
            end
            if (pslverr !== bad) begin
               error_count++;
               $display("Error: time %0t: pslverr %b at 0x%02h, expected %b",
                        $time, pslverr, paddr, bad);
            end
            if (!pwrite && !bad) begin
               read_count++;
               exp_data = expected_read(paddr);
               if (prdata !== exp_data) begin
                  error_count++;
                  $display("Error: time %0t: read of 0x%02h returned 0x%08h, expected 0x%08h",
                           $time, paddr, prdata, exp_data);
               end
            end
         end
         // a result lands two cycles after launch; a new start clears done again.
         if (stage_v[1]) begin
            res_m = stage_res[1];
         end
         if (start) begin
            done_m = 1'b0;
            busy_m = 1'b1;
         end else if (stage_v[1]) begin
            done_m = 1'b1;
            busy_m = 1'b0;
         end
         stage_v[1]   = stage_v[0];
         stage_res[1] = stage_res[0];
         stage_v[0]   = start;
         if (start) begin
            stage_res[0] = ref_add(op_m.a, op_m.b, pwdata[cska_pkg::ctrl_cin_bit]);
         end
         if (access && pwrite && !bad) begin
            case (paddr)
               cska_pkg::reg_a_lo: op_m.a[31:0]  = pwdata;
               cska_pkg::reg_a_hi: op_m.a[63:32] = pwdata;
               cska_pkg::reg_b_lo: op_m.b[31:0]  = pwdata;
               cska_pkg::reg_b_hi: op_m.b[63:32] = pwdata;
               cska_pkg::reg_ctrl: op_m.cin      = pwdata[cska_pkg::ctrl_cin_bit];
               default: ;
            endcase
         end
      end
   end

endmodule

/* sim/cska_apb_tb.sv */
`timescale 1ns/1ps

module cska_apb_tb;

   localparam int n_random = 200;
   // reset reads, four directed sums, timing, illegal access and two overlap cases.
   localparam int n_tests        = 9 + n_random;
   localparam int timeout_cycles = n_tests * 20 + 200;
   localparam int max_polls      = 8;

   logic                clk;
   logic                rst;
   cska_pkg::apb_addr_t paddr;
   logic                psel;
   logic                penable;
   logic                pwrite;
   cska_pkg::apb_data_t pwdata;
   cska_pkg::apb_data_t prdata;
   logic                pready;
   logic                pslverr;
   int                  seed;
   int                  tb_errors;
   int                  mon_errors;
   int                  mon_reads;

   cska_apb_top UUT (
      .clk     (clk),
      .rst     (rst),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   cska_apb_monitor u_mon (
      .clk         (clk),
      .rst         (rst),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .error_count (mon_errors),
      .read_count  (mon_reads)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // called on a falling edge and returns on the falling edge after the access phase.
   task automatic write_reg(input cska_pkg::apb_addr_t addr, input cska_pkg::apb_data_t data);
      paddr   = addr;
      pwdata  = data;
      pwrite  = 1'b1;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic read_reg(input cska_pkg::apb_addr_t addr, output cska_pkg::apb_data_t data);
      paddr   = addr;
      pwrite  = 1'b0;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      #1;
      data = prdata;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic wait_done();
      cska_pkg::apb_data_t st;
      int                  polls;
      polls = 0;
      do begin
         read_reg(cska_pkg::reg_status, st);
         polls++;
      end while (!st[cska_pkg::status_done_bit] && polls < max_polls);
      if (!st[cska_pkg::status_done_bit]) begin
         tb_errors++;
         $display("done bit still clear after %0d status polls at time %0t", max_polls, $time);
      end
   endtask

   task automatic run_add(input cska_pkg::word_t a, input cska_pkg::word_t b, input logic cin);
      cska_pkg::apb_data_t d;
      write_reg(cska_pkg::reg_a_lo, a[31:0]);
      write_reg(cska_pkg::reg_a_hi, a[63:32]);
      write_reg(cska_pkg::reg_b_lo, b[31:0]);
      write_reg(cska_pkg::reg_b_hi, b[63:32]);
      write_reg(cska_pkg::reg_ctrl, {30'd0, 1'b1, cin});
      wait_done();
      read_reg(cska_pkg::reg_sum_lo, d);
      read_reg(cska_pkg::reg_sum_hi, d);
   endtask

   initial begin : watchdog
      repeat (timeout_cycles) @(posedge clk);
      $display("timeout: run still going after %0d cycles", timeout_cycles);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin : stimulus
      cska_pkg::apb_data_t d;
      cska_pkg::word_t     ra;
      cska_pkg::word_t     rb;
      int                  total;
      seed      = 82;
      tb_errors = 0;
      rst       = 1'b1;
      paddr     = '0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      pwdata    = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      read_reg(cska_pkg::reg_status, d);
      read_reg(cska_pkg::reg_sum_lo, d);
      read_reg(cska_pkg::reg_sum_hi, d);
      read_reg(cska_pkg::reg_a_lo, d);
      read_reg(cska_pkg::reg_a_hi, d);
      read_reg(cska_pkg::reg_b_lo, d);
      read_reg(cska_pkg::reg_b_hi, d);

      // carries that ripple or skip across every block.
      run_add('1, 64'd1, 1'b0);
      run_add({16{4'hA}}, {16{4'h5}}, 1'b1);
      run_add({16{4'h5}}, {16{4'hA}}, 1'b0);
      run_add('0, '0, 1'b1);

      for (int i = 0; i < n_random; i++) begin
         ra = {$random(seed), $random(seed)};
         rb = {$random(seed), $random(seed)};
         d  = $random(seed);
         run_add(ra, rb, d[0]);
      end

      // status straight after a start and again two cycles later.
      write_reg(cska_pkg::reg_a_lo, 32'h1234_5678);
      write_reg(cska_pkg::reg_ctrl, 32'h2);
      read_reg(cska_pkg::reg_status, d);
      repeat (2) @(negedge clk);
      read_reg(cska_pkg::reg_status, d);
      read_reg(cska_pkg::reg_sum_lo, d);

      write_reg(8'h20, 32'hdead_beef);
      read_reg(8'h24, d);
      write_reg(8'h02, 32'hffff_ffff);
      write_reg(cska_pkg::reg_status, '1);
      write_reg(cska_pkg::reg_sum_lo, '1);
      write_reg(cska_pkg::reg_sum_hi, '1);
      for (int i = 0; i <= 7; i++) begin
         read_reg(cska_pkg::apb_addr_t'(i * 4), d);
      end

      // overlapping starts where the second result must win.
      write_reg(cska_pkg::reg_a_lo, '1);
      write_reg(cska_pkg::reg_a_hi, '1);
      write_reg(cska_pkg::reg_b_lo, '0);
      write_reg(cska_pkg::reg_b_hi, '0);
      write_reg(cska_pkg::reg_ctrl, 32'h2);
      write_reg(cska_pkg::reg_ctrl, 32'h3);
      wait_done();
      read_reg(cska_pkg::reg_sum_lo, d);
      read_reg(cska_pkg::reg_sum_hi, d);
      write_reg(cska_pkg::reg_ctrl, 32'h2);
      write_reg(cska_pkg::reg_a_lo, 32'h0);
      write_reg(cska_pkg::reg_ctrl, 32'h2);
      wait_done();
      read_reg(cska_pkg::reg_sum_lo, d);
      read_reg(cska_pkg::reg_sum_hi, d);

      total = tb_errors + mon_errors + UUT.u_regs.u_chk.fail_count +
              UUT.u_adder.u_chk.fail_count;
      $display("errors: checker %0d, testbench %0d, assertions %0d (%0d reads compared)",
               mon_errors, tb_errors,
               UUT.u_regs.u_chk.fail_count + UUT.u_adder.u_chk.fail_count, mon_reads);
      if (total == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* cska_apb_top.f */
design/cska_pkg.sv
design/cska_skip_block.sv
design/cska_group16.sv
design/cska_adder64.sv
design/cska_apb_regs.sv
design/cska_apb_top.sv
sim/cska_apb_chk.sv
sim/cska_apb_monitor.sv
sim/cska_apb_tb.sv

/* Bender.yml */
package:
  name: cska_apb

sources:
  - files:
      - design/cska_pkg.sv
      - design/cska_skip_block.sv
      - design/cska_group16.sv
      - design/cska_adder64.sv
      - design/cska_apb_regs.sv
      - design/cska_apb_top.sv
  - target: simulation
    files:
      - sim/cska_apb_chk.sv
      - sim/cska_apb_monitor.sv
      - sim/cska_apb_tb.sv
